// File: verilog.f
RiscvPkg.sv
Control.sv
ImmGen.sv
Alu.sv
BranchUnit.sv
DecodeExec.sv
DecodeExec_chk.sv
tbDecodeExec.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, pass is decided from the simulation log
verilator --binary --timing --assert --top-module tbDecodeExec -f verilog.f -o simv \
    > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tbDecodeExec.sv
`timescale 1ns/1ns

module tbDecodeExec;

    localparam int instCount   = 109;
    localparam int resetCycles = 10;
    localparam int gapCycles   = 20;
    localparam int testCycles  = instCount + resetCycles + gapCycles;

    logic                      clk;
    logic                      rstN;
    logic                      instValid;
    logic [31:0]               inst;
    logic [31:0]               pc;
    logic [31:0]               rs1Data;
    logic [31:0]               rs2Data;
    logic                      outValid;
    RiscvPkg::exMemT           out;

    RiscvPkg::exMemT expQ[$];
    string           nameQ[$];
    int              dueQ[$];
    int              cycle;
    int              mismatchErrs;
    int              otherErrs;

    DecodeExec DUT (
        .clk(clk), .rstN(rstN), .instValid(instValid), .inst(inst), .pc(pc),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .outValid(outValid), .out(out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle++;

    // instruction encoders, rs1 = x1, rs2 = x2
    function automatic logic [31:0] rType(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'(RiscvPkg::opArtLog)};
    endfunction

    function automatic logic [31:0] iType(logic [11:0] imm, logic [2:0] f3, logic [6:0] op);
        return {imm, 5'd1, f3, 5'd5, op};
    endfunction

    function automatic logic [31:0] sType(logic [11:0] imm, logic [2:0] f3);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'(RiscvPkg::opStore)};
    endfunction

    function automatic logic [31:0] bType(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11],
                7'(RiscvPkg::opBranch)};
    endfunction

    function automatic logic [31:0] jType(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'(RiscvPkg::opJal)};
    endfunction

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic isM, logic alt,
                                           logic [31:0] x, logic [31:0] y);
        logic [63:0] p;
        logic [4:0]  sh;
        sh = y[4:0];
        if (isM) begin
            case (f3)
                3'd0: p = {32'b0, x} * {32'b0, y};
                3'd1: p = {{32{x[31]}}, x} * {{32{y[31]}}, y};
                3'd2: p = {{32{x[31]}}, x} * {32'b0, y};
                3'd3: p = {32'b0, x} * {32'b0, y};
                default: p = '0;
            endcase
            case (f3)
                3'd0: return p[31:0];
                3'd1, 3'd2, 3'd3: return p[63:32];
                3'd4: begin
                    if (y == 0) return '1;
                    if (x == 32'h8000_0000 && y == '1) return x;
                    return 32'($signed(x) / $signed(y));
                end
                3'd6: begin
                    if (y == 0) return x;
                    if (x == 32'h8000_0000 && y == '1) return '0;
                    return 32'($signed(x) % $signed(y));
                end
                default: return x + y;
            endcase
        end
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << sh;
            3'd2: return {31'b0, $signed(x) < $signed(y)};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            3'd5: return alt ? 32'($signed(x) >>> sh) : x >> sh;
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // expected EX/MEM record from the ISA rules
    function automatic RiscvPkg::exMemT refExec(logic [31:0] i, logic [31:0] p,
                                                logic [31:0] a, logic [31:0] b);
        RiscvPkg::exMemT e;
        logic [31:0]     imm;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic            alt;
        opc = i[6:0];
        f3  = i[14:12];
        alt = i[31:25] == 7'h20;
        case (opc)
            7'b0100011: imm = {{20{i[31]}}, i[31:25], i[11:7]};
            7'b1100011: imm = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            7'b0110111, 7'b0010111: imm = {i[31:12], 12'b0};
            7'b1101111: imm = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            default: imm = {{20{i[31]}}, i[31:20]};
        endcase
        e = '0;
        e.storeData = b;
        e.rd        = i[11:7];
        e.target    = p + imm;
        e.result    = a + b; // zero control is add on registers
        case (opc)
            7'b0110011: begin
                e.wb.regWrite = 1'b1;
                e.result = aluRef(f3, i[31:25] == 7'h01, alt && (f3 == 3'd0 || f3 == 3'd5),
                                  a, b);
            end
            7'b0010011: begin
                e.wb.regWrite = 1'b1;
                e.result = aluRef(f3, 1'b0, alt && f3 == 3'd5, a, imm);
            end
            7'b0000011: begin
                e.result = a + imm;
                e.mem.memRead = 1'b1;
                e.wb = '{regWrite: 1'b1, memToReg: 1'b1};
                case (f3)
                    3'd0: e.mem.memOp = RiscvPkg::memLb;
                    3'd1: e.mem.memOp = RiscvPkg::memLh;
                    3'd2: e.mem.memOp = RiscvPkg::memLw;
                    3'd4: e.mem.memOp = RiscvPkg::memLbu;
                    3'd5: e.mem.memOp = RiscvPkg::memLhu;
                    default: e.mem.memOp = RiscvPkg::memNone;
                endcase
            end
            7'b0100011: begin
                e.result = a + imm;
                e.mem.memWrite = 1'b1;
                case (f3)
                    3'd0: e.mem.memOp = RiscvPkg::memSb;
                    3'd1: e.mem.memOp = RiscvPkg::memSh;
                    3'd2: e.mem.memOp = RiscvPkg::memSw;
                    default: e.mem.memOp = RiscvPkg::memNone;
                endcase
            end
            7'b1100011: begin
                case (f3)
                    3'd0: e.branchTaken = a == b;
                    3'd1: e.branchTaken = a != b;
                    3'd4: e.branchTaken = $signed(a) < $signed(b);
                    3'd5: e.branchTaken = $signed(a) >= $signed(b);
                    3'd6: e.branchTaken = a < b;
                    3'd7: e.branchTaken = a >= b;
                    default: e.branchTaken = 1'b0;
                endcase
            end
            7'b1100111: begin
                e.result      = p + 4;
                e.branchTaken = 1'b1;
                e.target      = (a + imm) & ~32'd1;
                e.wb.regWrite = 1'b1;
            end
            7'b1101111: begin
                e.result      = p + 4;
                e.branchTaken = 1'b1;
                e.wb.regWrite = 1'b1;
            end
            7'b0110111: begin
                e.result      = a + imm;
                e.wb.regWrite = 1'b1;
            end
            7'b0010111: begin
                e.result      = p + imm;
                e.wb.regWrite = 1'b1;
            end
            default: ; // ecall and unknown are bubbles
        endcase
        return e;
    endfunction

    task automatic sendInst(string name, logic [31:0] i, logic [31:0] a, logic [31:0] b);
        logic [31:0] p;
        p = {$urandom} & 32'hffff_fffc;
        @(posedge clk);
        #1;
        instValid = 1'b1;
        inst      = i;
        pc        = p;
        rs1Data   = a;
        rs2Data   = b;
        expQ.push_back(refExec(i, p, a, b));
        nameQ.push_back(name);
        dueQ.push_back(cycle + 2); // sampled next edge, registered out one edge later
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instValid = 1'b0;
            inst      = {$urandom};
        end
    endtask

    task automatic checkField(string test, string field, logic [31:0] e, logic [31:0] a);
        assert (e == a) else begin
            mismatchErrs++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, e, a);
        end
    endtask

    always @(negedge clk) begin
        RiscvPkg::exMemT e;
        string           n;
        int              due;
        if (!rstN) begin
            assert (!outValid && !out.mem.memWrite && !out.wb.regWrite) else begin
                otherErrs++;
                $display("outputs active while reset is held");
            end
        end else if (outValid) begin
            if (expQ.size() == 0) begin
                otherErrs++;
                $display("output strobe with no instruction outstanding");
            end else begin
                e   = expQ.pop_front();
                n   = nameQ.pop_front();
                due = dueQ.pop_front();
                assert (cycle == due) else begin
                    otherErrs++;
                    $display("%s came out at cycle %0d instead of cycle %0d", n, cycle, due);
                end
                checkField(n, "result", e.result, out.result);
                checkField(n, "storeData", e.storeData, out.storeData);
                checkField(n, "branchTaken", 32'(e.branchTaken), 32'(out.branchTaken));
                checkField(n, "target", e.target, out.target);
                checkField(n, "mem", 32'(e.mem), 32'(out.mem));
                checkField(n, "wb", 32'(e.wb), 32'(out.wb));
                checkField(n, "rd", 32'(e.rd), 32'(out.rd));
            end
        end
    end

    initial begin
        #((testCycles + 20) * 4);
        $display("timeout, run did not finish within %0d cycles", testCycles + 20);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [9:0]  rCodes [16];
        logic [2:0]  iF3 [6];
        logic [2:0]  bF3 [6];
        logic [31:0] bA [3];
        logic [31:0] bB [3];
        logic [4:0]  sh;
        void'($urandom(32'h6d6f6977));
        rCodes = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2},
                   {7'h00, 3'd3}, {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5},
                   {7'h00, 3'd6}, {7'h00, 3'd7}, {7'h01, 3'd0}, {7'h01, 3'd1},
                   {7'h01, 3'd2}, {7'h01, 3'd3}, {7'h01, 3'd4}, {7'h01, 3'd6}};
        iF3 = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
        bF3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        bA  = '{32'h1234_5678, 32'hffff_fffb, 32'h7fff_ffff};
        bB  = '{32'h1234_5678, 32'h0000_0003, 32'h8000_0000};
        cycle        = 0;
        mismatchErrs = 0;
        otherErrs    = 0;
        rstN         = 1'b0;
        instValid    = 1'b0;
        inst         = '0;
        pc           = '0;
        rs1Data      = '0;
        rs2Data      = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        idleCycles(2);

        // R-type, back to back
        for (int k = 0; k < 16; k++) begin
            for (int r = 0; r < 3; r++) begin
                sendInst($sformatf("rtype f7=%h f3=%0d", rCodes[k][9:3], rCodes[k][2:0]),
                         rType(rCodes[k][9:3], rCodes[k][2:0], 5'(k + 1)), $urandom, $urandom);
            end
        end
        sendInst("div by zero", rType(7'h01, 3'd4, 5'd3), $urandom, 32'd0);
        sendInst("rem by zero", rType(7'h01, 3'd6, 5'd3), $urandom, 32'd0);
        sendInst("div overflow", rType(7'h01, 3'd4, 5'd3), 32'h8000_0000, '1);
        sendInst("rem overflow", rType(7'h01, 3'd6, 5'd3), 32'h8000_0000, '1);
        idleCycles(2);

        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 6; k++) begin
                sendInst($sformatf("itype f3=%0d", iF3[k]),
                         iType(12'($urandom), iF3[k], 7'(RiscvPkg::opArtImm)), $urandom, 0);
            end
            sh = 5'($urandom);
            sendInst("slli", iType({7'h00, sh}, 3'd1, 7'(RiscvPkg::opArtImm)), $urandom, 0);
            sendInst("srli", iType({7'h00, sh}, 3'd5, 7'(RiscvPkg::opArtImm)), $urandom, 0);
            sendInst("srai", iType({7'h20, sh}, 3'd5, 7'(RiscvPkg::opArtImm)), $urandom, 0);
            sendInst("lui", {20'($urandom), 5'd4, 7'(RiscvPkg::opLui)}, 32'd0, $urandom);
            sendInst("auipc", {20'($urandom), 5'd4, 7'(RiscvPkg::opAuipc)}, $urandom, 0);
        end
        idleCycles(2);

        foreach (iF3[k]) begin
            if (k < 5)
                sendInst($sformatf("load f3=%0d", k == 3 ? 3'd4 : (k == 4 ? 3'd5 : 3'(k))),
                         iType(12'($urandom), k == 3 ? 3'd4 : (k == 4 ? 3'd5 : 3'(k)),
                               7'(RiscvPkg::opLoad)), $urandom, $urandom);
        end
        for (int k = 0; k < 3; k++) begin
            sendInst($sformatf("store f3=%0d", k), sType(12'($urandom), 3'(k)),
                     $urandom, $urandom);
        end
        idleCycles(2);

        for (int k = 0; k < 6; k++) begin
            for (int r = 0; r < 3; r++) begin
                sendInst($sformatf("branch f3=%0d pair %0d", bF3[k], r),
                         bType({12'($urandom), 1'b0}, bF3[k]), bA[r], bB[r]);
            end
        end
        sendInst("jal", jType({20'($urandom), 1'b0}), $urandom, $urandom);
        sendInst("jalr", iType(12'($urandom), 3'd0, 7'(RiscvPkg::opJalr)), $urandom, 0);
        sendInst("jalr odd", iType(12'h001, 3'd0, 7'(RiscvPkg::opJalr)), 32'h100, 0);
        idleCycles(2);

        // bubbles and streaming with gaps
        sendInst("ecall", 32'h0000_0073, $urandom, $urandom);
        idleCycles(1);
        sendInst("unknown opcode", {25'($urandom), 7'h7f}, $urandom, $urandom);
        idleCycles(1);
        sendInst("stream add", rType(7'h00, 3'd0, 5'd7), $urandom, $urandom);
        sendInst("stream mul", rType(7'h01, 3'd0, 5'd8), $urandom, $urandom);
        idleCycles(1);
        sendInst("stream addi", iType(12'($urandom), 3'd0, 7'(RiscvPkg::opArtImm)), $urandom, 0);
        sendInst("stream sw", sType(12'($urandom), 3'd2), $urandom, $urandom);
        idleCycles(1);

        idleCycles(3); // fixed two-cycle latency, pipe is empty by now
        if (expQ.size() != 0) begin
            otherErrs++;
            $display("%0d expected results never came out", expQ.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatchErrs, otherErrs);
        if (mismatchErrs + otherErrs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: DecodeExec_chk.sv
`timescale 1ns/1ns

module DecodeExec_chk (
    input logic            clk,
    input logic            rstN,
    input logic            instValid,
    input logic            outValid,
    input RiscvPkg::exMemT out
);

    // two-stage latency, no drops
    property strobeForward;
        @(posedge clk) disable iff (!rstN) instValid |-> ##2 outValid;
    endproperty

    property strobeBackward;
        @(posedge clk) disable iff (!rstN) outValid |-> $past(instValid, 2);
    endproperty

    aStrobeForward:  assert property (strobeForward) else $error("outValid missing");
    aStrobeBackward: assert property (strobeBackward) else $error("outValid without input");

    aResetLow: assert property (@(posedge clk) !rstN && $past(!rstN) |-> !outValid)
        else $error("outValid high in reset");

    aMemExclusive: assert property (@(posedge clk) disable iff (!rstN)
                                    !(out.mem.memWrite && out.mem.memRead))
        else $error("memWrite and memRead both high");

endmodule

bind DecodeExec DecodeExec_chk chk (.*);

// File: DecodeExec.sv
`timescale 1ns/1ns

module DecodeExec (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instValid,
    input  logic [RiscvPkg::xlen-1:0] inst,
    input  logic [RiscvPkg::xlen-1:0] pc,
    input  logic [RiscvPkg::xlen-1:0] rs1Data,
    input  logic [RiscvPkg::xlen-1:0] rs2Data,
    output logic                      outValid,
    output RiscvPkg::exMemT           out
);

    RiscvPkg::ctrlT            ctrl;
    logic [RiscvPkg::xlen-1:0] imm;
    RiscvPkg::idExT            idEx;
    logic                      exValid;
    logic [RiscvPkg::xlen-1:0] aluResult;
    logic [RiscvPkg::xlen-1:0] linkOrAlu;
    logic                      branchTaken;
    logic [RiscvPkg::xlen-1:0] target;

    Control uControl (.inst(inst), .totalCtrl(ctrl));
    ImmGen  uImmGen  (.inst(inst), .imm(imm));

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
            idEx    <= '0;
        end else begin
            exValid <= instValid;
            if (instValid) begin
                idEx.ctrl    <= ctrl;
                idEx.pc      <= pc;
                idEx.rs1Data <= rs1Data;
                idEx.rs2Data <= rs2Data;
                idEx.imm     <= imm;
                idEx.rd      <= inst[11:7];
            end
        end
    end

    Alu uAlu (
        .ex(idEx.ctrl.ex), .pc(idEx.pc), .rs1Data(idEx.rs1Data), .rs2Data(idEx.rs2Data),
        .imm(idEx.imm), .result(aluResult)
    );

    BranchUnit uBranchUnit (
        .ex(idEx.ctrl.ex), .pc(idEx.pc), .rs1Data(idEx.rs1Data), .rs2Data(idEx.rs2Data),
        .imm(idEx.imm), .branchTaken(branchTaken), .target(target)
    );

    // jalr uses the alu for rs1+imm, so link value comes from here
    assign linkOrAlu = idEx.ctrl.ex.jalr ? idEx.pc + RiscvPkg::xlen'(4) : aluResult;

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            out      <= '0;
        end else begin
            outValid <= exValid;
            if (exValid) begin
                out.result      <= linkOrAlu;
                out.storeData   <= idEx.rs2Data;
                out.branchTaken <= branchTaken;
                out.target      <= target;
                out.mem         <= idEx.ctrl.mem;
                out.wb          <= idEx.ctrl.wb;
                out.rd          <= idEx.rd;
            end
        end
    end

endmodule

// File: BranchUnit.sv
`timescale 1ns/1ns

module BranchUnit (
    input  RiscvPkg::exCtrlT          ex,
    input  logic [RiscvPkg::xlen-1:0] pc,
    input  logic [RiscvPkg::xlen-1:0] rs1Data,
    input  logic [RiscvPkg::xlen-1:0] rs2Data,
    input  logic [RiscvPkg::xlen-1:0] imm,
    output logic                      branchTaken,
    output logic [RiscvPkg::xlen-1:0] target
);

    logic                      isEq;
    logic                      isLt;
    logic                      isLtu;
    logic [RiscvPkg::xlen-1:0] jalrSum;

    assign isEq  = rs1Data == rs2Data;
    assign isLt  = $signed(rs1Data) < $signed(rs2Data);
    assign isLtu = rs1Data < rs2Data;

    always_comb begin
        unique case (ex.bruOp)
            RiscvPkg::bruEq:  branchTaken = isEq;
            RiscvPkg::bruNe:  branchTaken = !isEq;
            RiscvPkg::bruLt:  branchTaken = isLt;
            RiscvPkg::bruGe:  branchTaken = !isLt;
            RiscvPkg::bruLtu: branchTaken = isLtu;
            RiscvPkg::bruGeu: branchTaken = !isLtu;
            RiscvPkg::bruJmp: branchTaken = 1'b1;
            default:          branchTaken = 1'b0;
        endcase
    end

    assign jalrSum = rs1Data + imm;
    assign target  = ex.jalr ? {jalrSum[RiscvPkg::xlen-1:1], 1'b0} : pc + imm; // jalr drops bit 0

endmodule

// File: Alu.sv
`timescale 1ns/1ns

module Alu (
    input  RiscvPkg::exCtrlT          ex,
    input  logic [RiscvPkg::xlen-1:0] pc,
    input  logic [RiscvPkg::xlen-1:0] rs1Data,
    input  logic [RiscvPkg::xlen-1:0] rs2Data,
    input  logic [RiscvPkg::xlen-1:0] imm,
    output logic [RiscvPkg::xlen-1:0] result
);

    localparam int w = RiscvPkg::xlen;

    logic [w-1:0]   opA;
    logic [w-1:0]   opB;
    logic [4:0]     shamt;
    logic [2*w-1:0] prodSS;
    logic [2*w-1:0] prodSU;
    logic [2*w-1:0] prodUU;
    logic [w-1:0]   quot;
    logic [w-1:0]   remd;
    logic           divZero;
    logic           divOvf;

    always_comb begin
        unique case (ex.aluSrc)
            RiscvPkg::srcReg:    {opA, opB} = {rs1Data, rs2Data};
            RiscvPkg::srcImm:    {opA, opB} = {rs1Data, imm};
            RiscvPkg::srcPcFour: {opA, opB} = {pc, w'(4)};
            default:             {opA, opB} = {pc, imm};
        endcase
    end

    assign shamt = opB[4:0];

    // full-width products of extended operands, low 2w bits are exact
    assign prodSS = {{w{opA[w-1]}}, opA} * {{w{opB[w-1]}}, opB};
    assign prodSU = {{w{opA[w-1]}}, opA} * {{w{1'b0}}, opB};
    assign prodUU = {{w{1'b0}}, opA} * {{w{1'b0}}, opB};

    assign divZero = opB == '0;
    assign divOvf  = opA == {1'b1, {(w-1){1'b0}}} && opB == '1;
    assign quot    = (divZero || divOvf) ? '0 : w'($signed(opA) / $signed(opB));
    assign remd    = (divZero || divOvf) ? '0 : w'($signed(opA) % $signed(opB));

    always_comb begin
        unique case (ex.aluOp)
            RiscvPkg::aluAdd:    result = opA + opB;
            RiscvPkg::aluSub:    result = opA - opB;
            RiscvPkg::aluSll:    result = opA << shamt;
            RiscvPkg::aluSlt:    result = {{(w-1){1'b0}}, $signed(opA) < $signed(opB)};
            RiscvPkg::aluSltu:   result = {{(w-1){1'b0}}, opA < opB};
            RiscvPkg::aluXor:    result = opA ^ opB;
            RiscvPkg::aluSrl:    result = opA >> shamt;
            RiscvPkg::aluSra:    result = w'($signed(opA) >>> shamt);
            RiscvPkg::aluOr:     result = opA | opB;
            RiscvPkg::aluAnd:    result = opA & opB;
            RiscvPkg::aluMul:    result = prodUU[w-1:0];
            RiscvPkg::aluMulh:   result = prodSS[2*w-1:w];
            RiscvPkg::aluMulhsu: result = prodSU[2*w-1:w];
            RiscvPkg::aluMulhu:  result = prodUU[2*w-1:w];
            RiscvPkg::aluDiv:    result = divZero ? '1 : (divOvf ? opA : quot);
            RiscvPkg::aluRem:    result = divZero ? opA : (divOvf ? '0 : remd);
            default:             result = '0;
        endcase
    end

endmodule

// File: ImmGen.sv
`timescale 1ns/1ns

module ImmGen (
    input  logic [RiscvPkg::xlen-1:0] inst,
    output logic [RiscvPkg::xlen-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        unique case (RiscvPkg::opcodeT'(inst[6:0]))
            RiscvPkg::opStore: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            RiscvPkg::opBranch: begin
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            RiscvPkg::opLui, RiscvPkg::opAuipc: begin
                imm = {inst[31:12], 12'b0};
            end
            RiscvPkg::opJal: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, inst[31:20]}; // I format, shamt in low bits
            end
        endcase
    end

endmodule

// File: Control.sv
`timescale 1ns/1ns

module Control (
    input  logic [RiscvPkg::xlen-1:0] inst,
    output RiscvPkg::ctrlT            totalCtrl
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isAlt;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign isAlt  = funct7 == RiscvPkg::f7Alt;

    // base integer ops, shared by reg and imm forms
    function automatic RiscvPkg::aluOpT baseOp(input logic [2:0] f3, input logic sub,
                                               input logic sra);
        RiscvPkg::aluOpT op;
        unique case (f3)
            RiscvPkg::f3Add:  op = sub ? RiscvPkg::aluSub : RiscvPkg::aluAdd;
            RiscvPkg::f3Sll:  op = RiscvPkg::aluSll;
            RiscvPkg::f3Slt:  op = RiscvPkg::aluSlt;
            RiscvPkg::f3Sltu: op = RiscvPkg::aluSltu;
            RiscvPkg::f3Xor:  op = RiscvPkg::aluXor;
            RiscvPkg::f3Srl:  op = sra ? RiscvPkg::aluSra : RiscvPkg::aluSrl;
            RiscvPkg::f3Or:   op = RiscvPkg::aluOr;
            default:          op = RiscvPkg::aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        totalCtrl = '0;
        unique case (RiscvPkg::opcodeT'(inst[6:0]))
            RiscvPkg::opArtLog: begin
                if (funct7 == RiscvPkg::f7Mul) begin
                    unique case (funct3)
                        RiscvPkg::f3Mul:    totalCtrl.ex.aluOp = RiscvPkg::aluMul;
                        RiscvPkg::f3Mulh:   totalCtrl.ex.aluOp = RiscvPkg::aluMulh;
                        RiscvPkg::f3Mulhsu: totalCtrl.ex.aluOp = RiscvPkg::aluMulhsu;
                        RiscvPkg::f3Mulhu:  totalCtrl.ex.aluOp = RiscvPkg::aluMulhu;
                        RiscvPkg::f3Div:    totalCtrl.ex.aluOp = RiscvPkg::aluDiv;
                        RiscvPkg::f3Rem:    totalCtrl.ex.aluOp = RiscvPkg::aluRem;
                        default:            totalCtrl.ex.aluOp = RiscvPkg::aluAdd; // no divu/remu
                    endcase
                end else begin
                    totalCtrl.ex.aluOp = baseOp(funct3, isAlt, isAlt);
                end
                totalCtrl.ex.aluSrc  = RiscvPkg::srcReg;
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opArtImm: begin
                totalCtrl.ex.aluOp    = baseOp(funct3, 1'b0, isAlt); // no subi
                totalCtrl.ex.aluSrc   = RiscvPkg::srcImm;
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opLoad: begin
                totalCtrl.ex.aluSrc   = RiscvPkg::srcImm;
                totalCtrl.mem.memRead = 1'b1;
                totalCtrl.wb.regWrite = 1'b1;
                totalCtrl.wb.memToReg = 1'b1;
                unique case (funct3)
                    RiscvPkg::f3Lb:  totalCtrl.mem.memOp = RiscvPkg::memLb;
                    RiscvPkg::f3Lh:  totalCtrl.mem.memOp = RiscvPkg::memLh;
                    RiscvPkg::f3Lw:  totalCtrl.mem.memOp = RiscvPkg::memLw;
                    RiscvPkg::f3Lbu: totalCtrl.mem.memOp = RiscvPkg::memLbu;
                    RiscvPkg::f3Lhu: totalCtrl.mem.memOp = RiscvPkg::memLhu;
                    default:         totalCtrl.mem.memOp = RiscvPkg::memNone;
                endcase
            end
            RiscvPkg::opStore: begin
                totalCtrl.ex.aluSrc    = RiscvPkg::srcImm;
                totalCtrl.mem.memWrite = 1'b1;
                unique case (funct3)
                    RiscvPkg::f3Sb: totalCtrl.mem.memOp = RiscvPkg::memSb;
                    RiscvPkg::f3Sh: totalCtrl.mem.memOp = RiscvPkg::memSh;
                    RiscvPkg::f3Sw: totalCtrl.mem.memOp = RiscvPkg::memSw;
                    default:        totalCtrl.mem.memOp = RiscvPkg::memNone;
                endcase
            end
            RiscvPkg::opBranch: begin
                unique case (funct3)
                    RiscvPkg::f3Beq:  totalCtrl.ex.bruOp = RiscvPkg::bruEq;
                    RiscvPkg::f3Bne:  totalCtrl.ex.bruOp = RiscvPkg::bruNe;
                    RiscvPkg::f3Blt:  totalCtrl.ex.bruOp = RiscvPkg::bruLt;
                    RiscvPkg::f3Bge:  totalCtrl.ex.bruOp = RiscvPkg::bruGe;
                    RiscvPkg::f3Bltu: totalCtrl.ex.bruOp = RiscvPkg::bruLtu;
                    RiscvPkg::f3Bgeu: totalCtrl.ex.bruOp = RiscvPkg::bruGeu;
                    default:          totalCtrl.ex.bruOp = RiscvPkg::bruNop;
                endcase
            end
            RiscvPkg::opJalr: begin
                totalCtrl.ex.jalr     = 1'b1; // link value picked in top level
                totalCtrl.ex.bruOp    = RiscvPkg::bruJmp;
                totalCtrl.ex.aluSrc   = RiscvPkg::srcImm;
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opJal: begin
                totalCtrl.ex.bruOp    = RiscvPkg::bruJmp;
                totalCtrl.ex.aluSrc   = RiscvPkg::srcPcFour;
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opLui: begin
                totalCtrl.ex.aluSrc   = RiscvPkg::srcImm; // rs1 reads x0
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opAuipc: begin
                totalCtrl.ex.aluSrc   = RiscvPkg::srcPcImm;
                totalCtrl.wb.regWrite = 1'b1;
            end
            RiscvPkg::opEcall: totalCtrl = '0; // bubble, nothing written
            default:           totalCtrl = '0;
        endcase
    end

endmodule

// File: RiscvPkg.sv
package RiscvPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    typedef enum logic [6:0] {
        opArtLog = 7'b0110011,
        opArtImm = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opEcall  = 7'b1110011
    } opcodeT;

    localparam logic [6:0] f7Alt = 7'h20; // sub, sra
    localparam logic [6:0] f7Mul = 7'h01; // M extension

    // base arithmetic
    localparam logic [2:0] f3Add  = 3'b000;
    localparam logic [2:0] f3Sll  = 3'b001;
    localparam logic [2:0] f3Slt  = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor  = 3'b100;
    localparam logic [2:0] f3Srl  = 3'b101;
    localparam logic [2:0] f3Or   = 3'b110;
    localparam logic [2:0] f3And  = 3'b111;

    // multiply / divide
    localparam logic [2:0] f3Mul    = 3'b000;
    localparam logic [2:0] f3Mulh   = 3'b001;
    localparam logic [2:0] f3Mulhsu = 3'b010;
    localparam logic [2:0] f3Mulhu  = 3'b011;
    localparam logic [2:0] f3Div    = 3'b100;
    localparam logic [2:0] f3Rem    = 3'b110;

    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;
    localparam logic [2:0] f3Sb  = 3'b000;
    localparam logic [2:0] f3Sh  = 3'b001;
    localparam logic [2:0] f3Sw  = 3'b010;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluSra, aluOr, aluAnd,
        aluMul, aluMulh, aluMulhsu, aluMulhu, aluDiv, aluRem
    } aluOpT;

    typedef enum logic [2:0] {
        bruNop, bruEq, bruNe, bruLt, bruGe, bruLtu, bruGeu, bruJmp
    } bruOpT;

    typedef enum logic [1:0] {
        srcReg,    // rs1, rs2
        srcImm,    // rs1, imm
        srcPcFour, // pc, 4
        srcPcImm   // pc, imm
    } aluSrcT;

    // loads and stores share one code space, none is zero
    typedef enum logic [3:0] {
        memNone, memLb, memLh, memLw, memLbu, memLhu, memSb, memSh, memSw
    } memOpT;

    typedef struct packed {
        logic   jalr;
        bruOpT  bruOp;
        aluOpT  aluOp;
        aluSrcT aluSrc;
    } exCtrlT;

    typedef struct packed {
        memOpT memOp;
        logic  memWrite;
        logic  memRead;
    } memCtrlT;

    typedef struct packed {
        logic regWrite;
        logic memToReg; // load data instead of alu result
    } wbCtrlT;

    typedef struct packed {
        exCtrlT  ex;
        memCtrlT mem;
        wbCtrlT  wb;
    } ctrlT;

    typedef struct packed {
        ctrlT                ctrl;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1Data;
        logic [xlen-1:0]     rs2Data;
        logic [xlen-1:0]     imm;
        logic [regAddrW-1:0] rd;
    } idExT;

    typedef struct packed {
        logic [xlen-1:0]     result;    // write-back value
        logic [xlen-1:0]     storeData;
        logic                branchTaken;
        logic [xlen-1:0]     target;
        memCtrlT             mem;
        wbCtrlT              wb;
        logic [regAddrW-1:0] rd;
    } exMemT;

endpackage
